/* muldiv_settings.svh */
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// Operand and result width of the RV64 datapath.
`define XLEN 64

// Width of the destination-register tag.
`define TAG_WIDTH 5

// Multiplier latency in cycles.
`define MUL_STAGES 3

`endif

/* muldiv_pkg.sv */
`include "muldiv_settings.svh"

package muldiv_pkg;

    typedef enum logic [3:0] {
        MUL    = 4'd0,
        MULH   = 4'd1,
        MULHSU = 4'd2,
        MULHU  = 4'd3,
        DIV    = 4'd4,
        DIVU   = 4'd5,
        REM    = 4'd6,
        REMU   = 4'd7,
        MULW   = 4'd8,
        DIVW   = 4'd9,
        DIVUW  = 4'd10,
        REMW   = 4'd11,
        REMUW  = 4'd12
    } md_op_e;

    typedef logic [`TAG_WIDTH-1:0] md_tag_t;

    function automatic logic op_is_div(input md_op_e op);
        case (op)
            DIV, DIVU, REM, REMU, DIVW, DIVUW, REMW, REMUW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic op_is_word(input md_op_e op);
        case (op)
            MULW, DIVW, DIVUW, REMW, REMUW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

/* md_req_if.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

interface md_req_if;

    logic                 valid; // Single-cycle request strobe.
    muldiv_pkg::md_op_e   op;
    logic [`XLEN-1:0]     src1;
    logic [`XLEN-1:0]     src2;
    muldiv_pkg::md_tag_t  tag;

    modport issue (
        output valid,
        output op,
        output src1,
        output src2,
        output tag
    );

    modport mul (
        input valid,
        input op,
        input src1,
        input src2,
        input tag
    );

    modport div (
        input valid,
        input op,
        input src1,
        input src2,
        input tag
    );

endinterface

/* md_result_if.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

interface md_result_if;

    logic                 valid;
    logic [`XLEN-1:0]     result;  // Raw result before word sign-extension.
    muldiv_pkg::md_tag_t  tag;
    logic                 is_word;

    modport src (
        output valid,
        output result,
        output tag,
        output is_word
    );

    modport dst (
        input valid,
        input result,
        input tag,
        input is_word
    );

endinterface

/* mul_pipe.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

module mul_pipe (
    input  logic      clk,
    input  logic      rst_n,
    md_req_if.mul     req,
    md_result_if.src  res
);

    localparam int S = `MUL_STAGES;

    logic                       accept;
    logic                       a_signed;
    logic                       b_signed;
    logic [`XLEN-1:0]           src_a;
    logic [`XLEN-1:0]           src_b;

    logic [S-1:0]               vld_q;
    muldiv_pkg::md_tag_t        tag_q [S];
    muldiv_pkg::md_op_e         op_q [S];

    logic signed [`XLEN:0]      a_q;
    logic signed [`XLEN:0]      b_q;
    logic signed [2*`XLEN+1:0]  prod_q;
    logic [`XLEN-1:0]           result_q;

    assign accept = req.valid && !muldiv_pkg::op_is_div(req.op);

    // Operand extension to 65 bits depends on the signedness of each source.
    always_comb begin
        a_signed = (req.op != muldiv_pkg::MULHU);
        b_signed = (req.op == muldiv_pkg::MUL) || (req.op == muldiv_pkg::MULH) ||
                   (req.op == muldiv_pkg::MULW);
        if (req.op == muldiv_pkg::MULW) begin
            src_a = {{(`XLEN-32){req.src1[31]}}, req.src1[31:0]};
            src_b = {{(`XLEN-32){req.src2[31]}}, req.src2[31:0]};
        end else begin
            src_a = req.src1;
            src_b = req.src2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[S-2:0], accept};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= req.tag;
        op_q[0]  <= req.op;
        for (int i = 1; i < S; i++) begin
            tag_q[i] <= tag_q[i-1];
            op_q[i]  <= op_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= {a_signed & src_a[`XLEN-1], src_a};
            b_q <= {b_signed & src_b[`XLEN-1], src_b};
        end
        if (vld_q[0]) begin
            prod_q <= a_q * b_q;
        end
        if (vld_q[1]) begin
            case (op_q[1])
                muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU:
                    result_q <= prod_q[2*`XLEN-1:`XLEN];
                default:
                    result_q <= prod_q[`XLEN-1:0];
            endcase
        end
    end

    assign res.valid   = vld_q[S-1];
    assign res.result  = result_q;
    assign res.tag     = tag_q[S-1];
    assign res.is_word = muldiv_pkg::op_is_word(op_q[S-1]);

    a_known_op : assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> (!$isunknown(req.op) && req.op <= muldiv_pkg::REMUW))
        else $error("Request strobe carries an unknown operation.");

endmodule

/* div_iter.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

module div_iter (
    input  logic      clk,
    input  logic      rst_n,
    md_req_if.div     req,
    md_result_if.src  res,
    input  logic      div_held,
    output logic      busy
);

    localparam int CNT_W = $clog2(`XLEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FIN
    } state_e;

    state_e               state_q;
    logic [CNT_W-1:0]     count_q;
    logic                 res_valid_q;

    logic                 start;
    logic                 is_signed;
    logic [`XLEN-1:0]     op_a;
    logic [`XLEN-1:0]     op_b;
    logic [`XLEN-1:0]     min_neg;
    logic                 neg_a;
    logic                 neg_b;

    logic [`XLEN-1:0]     rem_q;
    logic [`XLEN-1:0]     quo_q;
    logic [`XLEN-1:0]     dvsr_q;
    logic [`XLEN-1:0]     dividend_q;
    logic                 q_neg_q;
    logic                 r_neg_q;
    logic                 zero_q;
    logic                 ovf_q;
    logic                 rem_sel_q;
    logic                 word_q;
    muldiv_pkg::md_tag_t  tag_q;
    logic [`XLEN-1:0]     result_q;

    logic [`XLEN:0]       shifted;
    logic [`XLEN:0]       diff;
    logic [`XLEN-1:0]     quo_fix;
    logic [`XLEN-1:0]     rem_fix;

    assign start = req.valid && muldiv_pkg::op_is_div(req.op) && (state_q == ST_IDLE);

    // Word forms run on the low halves, extended to the full width.
    always_comb begin
        is_signed = (req.op == muldiv_pkg::DIV) || (req.op == muldiv_pkg::REM) ||
                    (req.op == muldiv_pkg::DIVW) || (req.op == muldiv_pkg::REMW);
        if (muldiv_pkg::op_is_word(req.op)) begin
            op_a    = {{(`XLEN-32){is_signed & req.src1[31]}}, req.src1[31:0]};
            op_b    = {{(`XLEN-32){is_signed & req.src2[31]}}, req.src2[31:0]};
            min_neg = {{(`XLEN-31){1'b1}}, 31'd0};
        end else begin
            op_a    = req.src1;
            op_b    = req.src2;
            min_neg = {1'b1, {(`XLEN-1){1'b0}}};
        end
        neg_a = is_signed & op_a[`XLEN-1];
        neg_b = is_signed & op_b[`XLEN-1];
    end

    // One restoring step per cycle on the magnitudes.
    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    always_comb begin
        quo_fix = q_neg_q ? -quo_q : quo_q;
        rem_fix = r_neg_q ? -rem_q : rem_q;
        if (zero_q) begin
            quo_fix = '1;
            rem_fix = dividend_q;
        end else if (ovf_q) begin
            quo_fix = dividend_q;
            rem_fix = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            count_q     <= '0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= (state_q == ST_FIN);
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_RUN;
                        count_q <= '0;
                    end
                end
                ST_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_W'(`XLEN-1)) begin
                        state_q <= ST_FIN;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q      <= '0;
            quo_q      <= neg_a ? -op_a : op_a;
            dvsr_q     <= neg_b ? -op_b : op_b;
            dividend_q <= op_a;
            q_neg_q    <= neg_a ^ neg_b;
            r_neg_q    <= neg_a; // Remainder takes the sign of the dividend.
            zero_q     <= (op_b == '0);
            ovf_q      <= is_signed && (op_a == min_neg) && (op_b == '1);
            rem_sel_q  <= (req.op == muldiv_pkg::REM) || (req.op == muldiv_pkg::REMU) ||
                          (req.op == muldiv_pkg::REMW) || (req.op == muldiv_pkg::REMUW);
            word_q     <= muldiv_pkg::op_is_word(req.op);
            tag_q      <= req.tag;
        end else if (state_q == ST_RUN) begin
            if (!diff[`XLEN]) begin
                rem_q <= diff[`XLEN-1:0];
            end else begin
                rem_q <= shifted[`XLEN-1:0];
            end
            quo_q <= {quo_q[`XLEN-2:0], ~diff[`XLEN]};
        end
        if (state_q == ST_FIN) begin
            result_q <= rem_sel_q ? rem_fix : quo_fix;
        end
    end

    assign res.valid   = res_valid_q;
    assign res.result  = result_q;
    assign res.tag     = tag_q;
    assign res.is_word = word_q;

    // Busy also covers the cycles the result waits in the merge buffer.
    assign busy = (state_q != ST_IDLE) || res_valid_q || div_held;

    a_no_div_while_busy : assert property (@(posedge clk) disable iff (!rst_n)
        (req.valid && muldiv_pkg::op_is_div(req.op)) |-> !busy)
        else $error("Divide request issued while the divider is busy.");

endmodule

/* result_merge.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

module result_merge (
    input  logic                 clk,
    input  logic                 rst_n,
    md_result_if.dst             mul_res,
    md_result_if.dst             div_res,
    output logic                 div_held,
    output logic                 out_valid,
    output logic [`XLEN-1:0]     out_result,
    output muldiv_pkg::md_tag_t  out_tag
);

    logic                 held_q;
    logic [`XLEN-1:0]     buf_result_q;
    muldiv_pkg::md_tag_t  buf_tag_q;
    logic                 buf_word_q;

    logic                 collide;
    logic                 sel_valid;
    logic [`XLEN-1:0]     sel_result;
    logic                 sel_word;
    muldiv_pkg::md_tag_t  sel_tag;

    function automatic logic [`XLEN-1:0] word_ext(input logic [`XLEN-1:0] value,
                                                 input logic is_word);
        if (is_word) begin
            return {{(`XLEN-32){value[31]}}, value[31:0]};
        end
        return value;
    endfunction

    assign collide = mul_res.valid && div_res.valid;

    // Multiply first, then a buffered divide, then a fresh divide.
    always_comb begin
        sel_valid  = 1'b1;
        sel_result = mul_res.result;
        sel_tag    = mul_res.tag;
        sel_word   = mul_res.is_word;
        if (!mul_res.valid) begin
            if (held_q) begin
                sel_result = buf_result_q;
                sel_tag    = buf_tag_q;
                sel_word   = buf_word_q;
            end else begin
                sel_valid  = div_res.valid;
                sel_result = div_res.result;
                sel_tag    = div_res.tag;
                sel_word   = div_res.is_word;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= sel_valid;
            if (collide) begin
                held_q <= 1'b1;
            end else if (!mul_res.valid) begin
                held_q <= 1'b0; // Buffer drains in the first free cycle.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (collide) begin
            buf_result_q <= div_res.result;
            buf_tag_q    <= div_res.tag;
            buf_word_q   <= div_res.is_word;
        end
        out_result <= word_ext(sel_result, sel_word);
        out_tag    <= sel_tag;
    end

    assign div_held = held_q;

    a_no_overwrite : assert property (@(posedge clk) disable iff (!rst_n)
        collide |-> !held_q)
        else $error("Divide result collided while the merge buffer was full.");

endmodule

/* muldiv_unit.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

module muldiv_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  muldiv_pkg::md_op_e   req_op,
    input  logic [`XLEN-1:0]     req_src1,
    input  logic [`XLEN-1:0]     req_src2,
    input  muldiv_pkg::md_tag_t  req_tag,
    output logic                 out_valid,
    output logic [`XLEN-1:0]     out_result,
    output muldiv_pkg::md_tag_t  out_tag,
    output logic                 busy
);

    logic div_held;

    md_req_if    req_if ();
    md_result_if mul_res_if ();
    md_result_if div_res_if ();

    // Both units see every request and pick out their own class.
    assign req_if.valid = req_valid;
    assign req_if.op    = req_op;
    assign req_if.src1  = req_src1;
    assign req_if.src2  = req_src2;
    assign req_if.tag   = req_tag;

    mul_pipe u_mul_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_if.mul),
        .res   (mul_res_if.src)
    );

    div_iter u_div_iter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_if.div),
        .res      (div_res_if.src),
        .div_held (div_held),
        .busy     (busy)
    );

    result_merge u_result_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_res    (mul_res_if.dst),
        .div_res    (div_res_if.dst),
        .div_held   (div_held),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_tag    (out_tag)
    );

endmodule

/* tb_muldiv.sv */
`timescale 1ns/1ps
`include "muldiv_settings.svh"

module tb_muldiv;

    localparam int DIV_TIMEOUT = 4 * `XLEN;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    muldiv_pkg::md_op_e   req_op;
    logic [`XLEN-1:0]     req_src1;
    logic [`XLEN-1:0]     req_src2;
    muldiv_pkg::md_tag_t  req_tag;
    logic                 out_valid;
    logic [`XLEN-1:0]     out_result;
    muldiv_pkg::md_tag_t  out_tag;
    logic                 busy;

    logic [31:0]          lfsr;
    muldiv_pkg::md_tag_t  tag_ctr;
    muldiv_pkg::md_op_e   q_op [$];
    logic [`XLEN-1:0]     q_a [$];
    logic [`XLEN-1:0]     q_b [$];
    muldiv_pkg::md_tag_t  q_tag [$];

    muldiv_unit u_muldiv_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_src1   (req_src1),
        .req_src2   (req_src2),
        .req_tag    (req_tag),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_tag    (out_tag),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] rand_bits(input int n);
        logic [`XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // x^32+x^22+x^2+x+1.
            v = {v[`XLEN-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] with_garbage(input logic [31:0] lo);
        logic [`XLEN-1:0] hi;
        hi = rand_bits(`XLEN - 32);
        return {hi[`XLEN-33:0], lo};
    endfunction

    function automatic logic [`XLEN-1:0] sext32(input logic [31:0] v);
        return {{(`XLEN-32){v[31]}}, v};
    endfunction

    // Signed overflow needs no special case once the operands are 128 bits wide.
    function automatic logic [`XLEN-1:0] div_model(input logic signed [2*`XLEN-1:0] x,
                                                   input logic signed [2*`XLEN-1:0] y,
                                                   input logic want_rem,
                                                   input logic word);
        logic signed [2*`XLEN-1:0] r;
        if (y == '0) begin
            r = want_rem ? x : '1;
        end else begin
            r = want_rem ? x % y : x / y;
        end
        return word ? sext32(r[31:0]) : r[`XLEN-1:0];
    endfunction

    function automatic logic [`XLEN-1:0] ref_result(input muldiv_pkg::md_op_e op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        logic signed [2*`XLEN-1:0] sa;
        logic signed [2*`XLEN-1:0] sb;
        logic signed [2*`XLEN-1:0] ua;
        logic signed [2*`XLEN-1:0] ub;
        logic signed [2*`XLEN-1:0] wsa;
        logic signed [2*`XLEN-1:0] wsb;
        logic signed [2*`XLEN-1:0] wua;
        logic signed [2*`XLEN-1:0] wub;
        logic signed [2*`XLEN-1:0] p;
        sa  = {{`XLEN{a[`XLEN-1]}}, a};
        sb  = {{`XLEN{b[`XLEN-1]}}, b};
        ua  = {{`XLEN{1'b0}}, a};
        ub  = {{`XLEN{1'b0}}, b};
        wsa = {{(2*`XLEN-32){a[31]}}, a[31:0]};
        wsb = {{(2*`XLEN-32){b[31]}}, b[31:0]};
        wua = {{(2*`XLEN-32){1'b0}}, a[31:0]};
        wub = {{(2*`XLEN-32){1'b0}}, b[31:0]};
        case (op)
            muldiv_pkg::MULHSU: p = sa * ub;
            muldiv_pkg::MULHU:  p = ua * ub;
            muldiv_pkg::MULW:   p = wsa * wsb;
            default:            p = sa * sb;
        endcase
        case (op)
            muldiv_pkg::MUL:    return p[`XLEN-1:0];
            muldiv_pkg::MULH,
            muldiv_pkg::MULHSU,
            muldiv_pkg::MULHU:  return p[2*`XLEN-1:`XLEN];
            muldiv_pkg::MULW:   return sext32(p[31:0]);
            muldiv_pkg::DIV:    return div_model(sa, sb, 1'b0, 1'b0);
            muldiv_pkg::DIVU:   return div_model(ua, ub, 1'b0, 1'b0);
            muldiv_pkg::REM:    return div_model(sa, sb, 1'b1, 1'b0);
            muldiv_pkg::REMU:   return div_model(ua, ub, 1'b1, 1'b0);
            muldiv_pkg::DIVW:   return div_model(wsa, wsb, 1'b0, 1'b1);
            muldiv_pkg::DIVUW:  return div_model(wua, wub, 1'b0, 1'b1);
            muldiv_pkg::REMW:   return div_model(wsa, wsb, 1'b1, 1'b1);
            muldiv_pkg::REMUW:  return div_model(wua, wub, 1'b1, 1'b1);
            default:            return 'x;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_out(input muldiv_pkg::md_tag_t tag, input logic [`XLEN-1:0] exp);
        assert (out_valid && out_tag == tag && out_result == exp) else
            report_failure($sformatf("ERROR at %0t: tag %0d expected %h, got valid %b tag %0d %h",
                                     $time, tag, exp, out_valid, out_tag, out_result));
    endtask

    task automatic add_op(input muldiv_pkg::md_op_e op, input logic [`XLEN-1:0] a,
                          input logic [`XLEN-1:0] b);
        q_op.push_back(op);
        q_a.push_back(a);
        q_b.push_back(b);
        q_tag.push_back(tag_ctr);
        tag_ctr = tag_ctr + 1'b1;
    endtask

    task automatic clear_queue();
        q_op.delete();
        q_a.delete();
        q_b.delete();
        q_tag.delete();
    endtask

    task automatic drive_req(input int k);
        req_valid = 1'b1;
        req_op    = q_op[k];
        req_src1  = q_a[k];
        req_src2  = q_b[k];
        req_tag   = q_tag[k];
    endtask

    // Issues the queued multiplies on consecutive cycles; each must appear 4 cycles later.
    task automatic run_mul_burst();
        int k;
        for (int c = 0; c < q_op.size() + `MUL_STAGES; c++) begin
            if (c < q_op.size()) begin
                drive_req(c);
            end else begin
                req_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            k = c - `MUL_STAGES;
            if (k >= 0) begin
                check_out(q_tag[k], ref_result(q_op[k], q_a[k], q_b[k]));
            end else begin
                assert (!out_valid) else
                    report_failure($sformatf("ERROR at %0t: early out_valid", $time));
            end
        end
        req_valid = 1'b0;
        clear_queue();
    endtask

    task automatic run_div(input muldiv_pkg::md_op_e op, input logic [`XLEN-1:0] a,
                           input logic [`XLEN-1:0] b);
        int waited;
        add_op(op, a, b);
        drive_req(0);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        assert (busy && !out_valid) else
            report_failure($sformatf("ERROR at %0t: busy not raised by divide", $time));
        waited = 0;
        while (!out_valid) begin
            if (waited > DIV_TIMEOUT) begin
                report_failure("Timed out waiting for a divide result.");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        check_out(q_tag[0], ref_result(op, a, b));
        assert (!busy) else
            report_failure($sformatf("ERROR at %0t: busy still high after divide", $time));
        clear_queue();
    endtask

    task automatic test_mul_family();
        logic [`XLEN-1:0]   corner [3];
        muldiv_pkg::md_op_e ops [4];
        corner = '{'0, '1, {1'b1, {(`XLEN-1){1'b0}}}};
        ops    = '{muldiv_pkg::MUL, muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU};
        foreach (ops[o]) begin
            foreach (corner[i]) begin
                foreach (corner[j]) begin
                    add_op(ops[o], corner[i], corner[j]);
                    run_mul_burst();
                end
            end
            repeat (6) begin
                add_op(ops[o], rand_bits(`XLEN), rand_bits(`XLEN));
                run_mul_burst();
            end
        end
    endtask

    task automatic test_div_family();
        muldiv_pkg::md_op_e ops [4];
        ops = '{muldiv_pkg::DIV, muldiv_pkg::DIVU, muldiv_pkg::REM, muldiv_pkg::REMU};
        foreach (ops[o]) begin
            run_div(ops[o], rand_bits(`XLEN), rand_bits(`XLEN));
            run_div(ops[o], rand_bits(`XLEN), rand_bits(20));
            run_div(ops[o], rand_bits(`XLEN), ~rand_bits(12)); // Small negative divisor.
            run_div(ops[o], rand_bits(`XLEN), '0);
            run_div(ops[o], {1'b1, {(`XLEN-1){1'b0}}}, '1);
        end
    endtask

    task automatic test_word_forms();
        muldiv_pkg::md_op_e ops [4];
        ops = '{muldiv_pkg::DIVW, muldiv_pkg::DIVUW, muldiv_pkg::REMW, muldiv_pkg::REMUW};
        foreach (ops[o]) begin
            run_div(ops[o], rand_bits(`XLEN), rand_bits(`XLEN));
            run_div(ops[o], rand_bits(`XLEN), with_garbage(32'(rand_bits(10))));
            run_div(ops[o], rand_bits(`XLEN), with_garbage(32'd0));
            run_div(ops[o], with_garbage(32'h8000_0000), with_garbage(32'hffff_ffff));
        end
        add_op(muldiv_pkg::MULW, with_garbage(32'h8000_0000), with_garbage(32'hffff_ffff));
        add_op(muldiv_pkg::MULW, with_garbage(32'h8000_0000), with_garbage(32'h8000_0000));
        repeat (6) begin
            add_op(muldiv_pkg::MULW, rand_bits(`XLEN), rand_bits(`XLEN));
        end
        run_mul_burst();
    endtask

    task automatic test_back_to_back();
        muldiv_pkg::md_op_e ops [5];
        ops = '{muldiv_pkg::MUL, muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU,
                muldiv_pkg::MULW};
        for (int i = 0; i < 10; i++) begin
            add_op(ops[i % 5], rand_bits(`XLEN), rand_bits(`XLEN));
        end
        run_mul_burst();
    endtask

    // The first multiply is timed to reach the merge stage with the divide result.
    task automatic test_collision();
        logic [2:0] seen;
        int         waited;
        int         k;
        add_op(muldiv_pkg::DIV, rand_bits(`XLEN), rand_bits(24));
        add_op(muldiv_pkg::MUL, rand_bits(`XLEN), rand_bits(`XLEN));
        add_op(muldiv_pkg::MULHU, rand_bits(`XLEN), rand_bits(`XLEN));
        drive_req(0);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        repeat (`XLEN + 1 - `MUL_STAGES) @(posedge clk);
        #1;
        for (int i = 1; i < 3; i++) begin
            drive_req(i);
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        seen   = '0;
        waited = 0;
        while (seen != 3'b111) begin
            if (waited > 20) begin
                report_failure("Timed out waiting for the colliding results.");
            end
            if (out_valid) begin
                k = -1;
                foreach (q_tag[i]) begin
                    if (q_tag[i] == out_tag && !seen[i]) begin
                        k = i;
                    end
                end
                assert (k >= 0) else
                    report_failure($sformatf("ERROR at %0t: unexpected tag %0d", $time, out_tag));
                check_out(q_tag[k], ref_result(q_op[k], q_a[k], q_b[k]));
                seen[k] = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        assert (!out_valid && !busy) else
            report_failure($sformatf("ERROR at %0t: extra output or busy stuck", $time));
        clear_queue();
    endtask

    initial begin
        lfsr      = 32'h761b6fc6;
        tag_ctr   = '0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = muldiv_pkg::MUL;
        req_src1  = '0;
        req_src2  = '0;
        req_tag   = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            assert (!out_valid && !busy) else
                report_failure($sformatf("ERROR at %0t: output active after reset", $time));
            @(posedge clk);
            #1;
        end
        test_mul_family();
        test_div_family();
        test_word_forms();
        test_back_to_back();
        test_collision();
        $display("All tests passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
muldiv_pkg.sv
md_req_if.sv
md_result_if.sv
mul_pipe.sv
div_iter.sv
result_merge.sv
muldiv_unit.sv
tb_muldiv.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_muldiv -f tb.f

out=$(./obj_dir/Vtb_muldiv 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
